/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the run by the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --Wno-fatal --top-module coreTb \
  -f verilog.f -o coreTb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/coreTb > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Architectural state as the RV32I rules leave it, x0 stays zero
wordT modelRegs [`NUM_REGS] = '{default: '0};

function automatic wordT aluRef(logic [2:0] f3, logic alt, wordT a, wordT b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// One instruction in program order, returns the retire record it should produce
function automatic resultT modelStep(logic [31:0] ins, wordT pc);
  resultT     r;
  logic [2:0] f3;
  wordT       a;
  wordT       b;
  wordT       immI;
  wordT       immB;
  r    = '0;
  f3   = ins[14:12];
  a    = modelRegs[ins[19:15]];
  b    = modelRegs[ins[24:20]];
  immI = {{20{ins[31]}}, ins[31:20]};
  immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  r.pc = pc;
  r.rd = ins[11:7];
  case (ins[6:0])
    7'b0110011: begin
      r.regWrite = 1'b1;
      r.illegal  = (f3 == 3'b011) || (ins[30] && (f3 != 3'b000));  // No SLTU, no SRA
      r.value    = aluRef(f3, ins[30], a, b);
    end
    7'b0010011: begin
      r.regWrite = 1'b1;
      r.illegal  = (f3 == 3'b001) || (f3 == 3'b011) || (f3 == 3'b101);
      r.value    = aluRef(f3, 1'b0, a, immI);
    end
    7'b0110111: begin
      r.regWrite = 1'b1;
      r.value    = {ins[31:12], 12'b0};
    end
    7'b1100011: begin
      r.isBranch     = 1'b1;
      r.illegal      = f3[1];
      r.branchTarget = pc + immB;
      case (f3)
        3'b000:  r.branchTaken = (a == b);
        3'b001:  r.branchTaken = (a != b);
        3'b100:  r.branchTaken = ($signed(a) < $signed(b));
        default: r.branchTaken = ($signed(a) >= $signed(b));
      endcase
    end
    default: r.illegal = 1'b1;
  endcase
  if (r.illegal) begin
    r.regWrite    = 1'b0;
    r.isBranch    = 1'b0;
    r.branchTaken = 1'b0;
  end
  if (r.regWrite && (r.rd != '0)) modelRegs[r.rd] = r.value;
  return r;
endfunction

`endif

/* sim/coreTb.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTb;
  import coreTypes_pkg::*;

  localparam int WaitLimit  = 200;
  localparam int DrainLimit = 1000;

  logic        clk_i;
  logic        rstN_i;
  logic        instrValid_i;
  logic [31:0] instr_i;
  wordT        pc_i;
  logic        creditReturn_o;
  logic        retireValid_o;
  wordT        retirePc_o;
  regAddrT     retireRd_o;
  logic        retireWrite_o;
  wordT        retireValue_o;
  logic        retireBranch_o;
  logic        retireTaken_o;
  wordT        retireTarget_o;
  logic        retireIllegal_o;
  wordT        a0_o;

  logic [31:0] rngState = 32'h3610c16b;
  wordT        pcNext = 32'h0000_1000;
  logic        burst = 1'b0;  // Back-to-back sends without random spacing
  int          credits = `QUEUE_DEPTH;
  int          sent = 0;
  int          returned = 0;
  int          retired = 0;
  int          drainWait;
  int          valueErrs = 0;
  int          branchErrs = 0;
  int          flagErrs = 0;
  int          protoErrs = 0;
  logic [15:0] hi;
  logic [15:0] lo;
  resultT      expQ [$];
  string       nameQ [$];
  resultT      expRec;
  resultT      actRec;
  string       curName;

  `include "refModel.svh"

  riscCore u_riscCore (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [15:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[31:16];  // Low LCG bits have short periods
  endfunction

  function automatic logic [31:0] encR(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
                                       logic [2:0] f3, regAddrT rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
                                       regAddrT rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encU(logic [19:0] imm, regAddrT rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] off, regAddrT rs2, regAddrT rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] randomAluInstr();
    logic [15:0] r;
    logic [15:0] imm;
    int          sel;
    r   = nextRand();
    imm = nextRand();
    sel = int'(nextRand() % 13);
    case (sel)
      0:       return encR(7'h00, r[14:10], r[9:5], 3'b000, r[4:0]);
      1:       return encR(7'h20, r[14:10], r[9:5], 3'b000, r[4:0]);  // SUB
      2:       return encR(7'h00, r[14:10], r[9:5], 3'b111, r[4:0]);
      3:       return encR(7'h00, r[14:10], r[9:5], 3'b110, r[4:0]);
      4:       return encR(7'h00, r[14:10], r[9:5], 3'b100, r[4:0]);
      5:       return encR(7'h00, r[14:10], r[9:5], 3'b010, r[4:0]);
      6:       return encR(7'h00, r[14:10], r[9:5], 3'b001, r[4:0]);
      7:       return encR(7'h00, r[14:10], r[9:5], 3'b101, r[4:0]);
      8:       return encI(imm[11:0], r[9:5], 3'b000, r[4:0]);
      9:       return encI(imm[11:0], r[9:5], 3'b111, r[4:0]);
      10:      return encI(imm[11:0], r[9:5], 3'b110, r[4:0]);
      11:      return encI(imm[11:0], r[9:5], 3'b100, r[4:0]);
      default: return encI(imm[11:0], r[9:5], 3'b010, r[4:0]);
    endcase
  endfunction

  function automatic logic [31:0] randomBranch();
    logic [15:0] r;
    logic [15:0] off;
    logic [2:0]  f3;
    r   = nextRand();
    off = nextRand();
    case (r[11:10])
      2'd0:    f3 = 3'b000;
      2'd1:    f3 = 3'b001;
      2'd2:    f3 = 3'b100;
      default: f3 = 3'b101;
    endcase
    return encB({off[11:0], 1'b0}, r[9:5], r[4:0], f3);
  endfunction

  task automatic abortRun(string why);
    $display("Run stopped: %s", why);
    $display("Errors: value %0d, branch %0d, flags %0d, protocol %0d",
             valueErrs, branchErrs, flagErrs, protoErrs);
    $display("Testbench failed");
    $finish;
  endtask

  // One driver clock that counts returned credits at the falling edge
  task automatic stepCycle();
    @(negedge clk_i);
    if (creditReturn_o) begin
      credits++;
      returned++;
      if (credits > `QUEUE_DEPTH) begin
        $display("Credit count rose to %0d, above the queue depth", credits);
        protoErrs++;
      end
    end
  endtask

  task automatic sendInstr(logic [31:0] ins, string name);
    int gap;
    int waited;
    gap    = burst ? 0 : int'(nextRand() % 3);
    waited = 0;
    repeat (gap) stepCycle();
    while (credits == 0 && waited < WaitLimit) begin
      stepCycle();
      waited++;
    end
    if (credits == 0) begin
      abortRun("no credit came back from the core");
    end else begin
      instrValid_i = 1'b1;
      instr_i      = ins;
      pc_i         = pcNext;
      credits--;
      sent++;
      expQ.push_back(modelStep(ins, pcNext));
      nameQ.push_back(name);
      pcNext += 4;
      stepCycle();
      instrValid_i = 1'b0;
    end
  endtask

  task automatic compareValue(string what, wordT exp, wordT act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, actual %h", what, exp, act);
      valueErrs++;
    end
  endtask

  task automatic compareBranch(string what, resultT exp, resultT act);
    if ((exp.isBranch !== act.isBranch) || (exp.branchTaken !== act.branchTaken)
        || (exp.isBranch && (exp.branchTarget !== act.branchTarget))) begin
      $display("[FAIL] %s at pc %h: expected branch %b taken %b target %h, actual %b %b %h",
               what, exp.pc, exp.isBranch, exp.branchTaken, exp.branchTarget,
               act.isBranch, act.branchTaken, act.branchTarget);
      branchErrs++;
    end
  endtask

  task automatic compareFlags(string what, resultT exp, resultT act);
    if ((exp.rd !== act.rd) || (exp.regWrite !== act.regWrite)
        || (exp.illegal !== act.illegal)) begin
      $display("[FAIL] %s at pc %h: expected rd %0d write %b illegal %b, actual %0d %b %b",
               what, exp.pc, exp.rd, exp.regWrite, exp.illegal,
               act.rd, act.regWrite, act.illegal);
      flagErrs++;
    end
  endtask

  // Checker pops one expected record per retirement in program order
  always @(negedge clk_i) begin
    if (rstN_i && retireValid_o) begin
      if (expQ.size() == 0) begin
        $display("Retirement at pc %h arrived with nothing outstanding", retirePc_o);
        flagErrs++;
      end else begin
        expRec              = expQ.pop_front();
        curName             = nameQ.pop_front();
        actRec              = '0;
        actRec.pc           = retirePc_o;
        actRec.rd           = retireRd_o;
        actRec.regWrite     = retireWrite_o;
        actRec.value        = retireValue_o;
        actRec.isBranch     = retireBranch_o;
        actRec.branchTaken  = retireTaken_o;
        actRec.branchTarget = retireTarget_o;
        actRec.illegal      = retireIllegal_o;
        compareValue({curName, " pc"}, expRec.pc, actRec.pc);
        if (expRec.regWrite) compareValue({curName, " value"}, expRec.value, actRec.value);
        compareBranch(curName, expRec, actRec);
        compareFlags(curName, expRec, actRec);
        retired++;
      end
    end
  end

  initial begin
    rstN_i       = 1'b0;
    instrValid_i = 1'b0;
    instr_i      = '0;
    pc_i         = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rstN_i = 1'b1;

    // Every register gets a value and each ADDI waits on its LUI
    for (int i = 1; i < `NUM_REGS; i++) begin
      hi = nextRand();
      lo = nextRand();
      sendInstr(encU({hi[9:0], lo[9:0]}, regAddrT'(i)), "init");
      sendInstr(encI(lo[15:4], regAddrT'(i), 3'b000, regAddrT'(i)), "init");
    end

    sendInstr(encI(12'd123, 5'd5, 3'b000, 5'd0), "x0 write");
    sendInstr(encR(7'h00, 5'd6, 5'd0, 3'b000, 5'd7), "x0 read");
    sendInstr(encR(7'h00, 5'd0, 5'd0, 3'b110, 5'd8), "x0 read");

    burst = 1'b1;
    sendInstr(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd11), "dependent");
    sendInstr(encR(7'h20, 5'd3, 5'd11, 3'b000, 5'd12), "dependent");
    sendInstr(encR(7'h00, 5'd11, 5'd12, 3'b100, 5'd13), "dependent");
    sendInstr(encR(7'h00, 5'd12, 5'd13, 3'b010, 5'd14), "dependent");
    sendInstr(encI(12'hffb, 5'd14, 3'b000, 5'd10), "dependent");
    sendInstr(encI(12'd7, 5'd10, 3'b000, 5'd10), "dependent");  // rd still in flight
    burst = 1'b0;

    sendInstr(encB(13'd16, 5'd3, 5'd3, 3'b000), "branch");
    sendInstr(encB(13'd16, 5'd3, 5'd3, 3'b001), "branch");
    sendInstr(encB(13'h1ff0, 5'd0, 5'd0, 3'b100), "branch");
    sendInstr(encB(13'h1ff0, 5'd0, 5'd0, 3'b101), "branch");
    repeat (16) sendInstr(randomBranch(), "branch");

    sendInstr({12'h004, 5'd1, 3'b010, 5'd9, 7'b0000011}, "illegal");
    sendInstr({20'h00010, 5'd10, 7'b1101111}, "illegal");
    sendInstr(encR(7'h00, 5'd0, 5'd9, 3'b000, 5'd15), "illegal");
    sendInstr(encR(7'h00, 5'd0, 5'd10, 3'b000, 5'd16), "illegal");

    repeat (200) sendInstr(randomAluInstr(), "random");

    drainWait = 0;
    while ((retired != sent || returned != sent) && drainWait < DrainLimit) begin
      stepCycle();
      drainWait++;
    end
    if (retired != sent || returned != sent) begin
      abortRun("pipeline did not drain");
    end else begin
      repeat (8) stepCycle();  // Room for any stray retirement

      compareValue("a0 tap", modelRegs[10], a0_o);
      if (credits != `QUEUE_DEPTH) begin
        $display("Sender holds %0d credits at the end instead of all", credits);
        protoErrs++;
      end
      $display("Errors: value %0d, branch %0d, flags %0d, protocol %0d",
               valueErrs, branchErrs, flagErrs, protoErrs);
      if (valueErrs + branchErrs + flagErrs + protoErrs == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+sim
verilog/coreTypes_pkg.sv
verilog/stageIf.sv
verilog/instrQueue.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/riscCore.sv
sim/coreTb.sv

/* verilog/coreTypes_pkg.sv */
`include "core_macros.svh"

package coreTypes_pkg;

  typedef logic [$clog2(`NUM_REGS)-1:0] regAddrT;
  typedef logic [`XLEN-1:0]             wordT;

  // Opcodes this core recognizes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011
  } opcodeE;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASSB
  } aluOpE;

  // Main decoder outputs
  typedef struct packed {
    logic  regWrite;
    logic  useImm;   // opB from immediate instead of rs2
    logic  useRs2;   // rs2 read is needed, so it counts for hazards
    logic  isBranch;
    logic  illegal;
    aluOpE aluOp;
  } ctrlT;

  typedef struct packed {
    logic [31:0] instr;
    wordT        pc;
  } instrT;

  typedef struct packed {
    wordT    pc;
    regAddrT rd;
    logic    regWrite;
    aluOpE   aluOp;
    wordT    opA;
    wordT    opB;
    logic    isBranch;
    logic    branchTaken;
    wordT    branchTarget;
    logic    illegal;
  } decodedT;

  typedef struct packed {
    wordT    pc;
    regAddrT rd;
    logic    regWrite;
    wordT    value;
    logic    isBranch;
    logic    branchTaken;
    wordT    branchTarget;
    logic    illegal;
  } resultT;

endpackage

/* verilog/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width in bits
`define XLEN 32

// Architectural integer registers, x0 included
`define NUM_REGS 32

// Instruction queue entries, also the sender's initial credit count
`define QUEUE_DEPTH 4

`endif

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module decodeStage (
  input  logic                   clk_i,
  input  logic                   rstN_i,
  input  logic                   headValid_i,
  input  coreTypes_pkg::instrT   headData_i,
  output logic                   take_o,
  output coreTypes_pkg::regAddrT rdAddrA_o,
  output coreTypes_pkg::regAddrT rdAddrB_o,
  input  coreTypes_pkg::wordT    rdDataA_i,
  input  coreTypes_pkg::wordT    rdDataB_i,
  input  logic                   releaseEn_i,
  input  coreTypes_pkg::regAddrT releaseAddr_i,
  decodeExIf.source              exOut
);
  import coreTypes_pkg::*;

  logic [31:0]          instr;
  logic [2:0]           funct3;
  regAddrT              rd;
  ctrlT                 ctrl;
  wordT                 imm;
  wordT                 immI;
  wordT                 immU;
  wordT                 immB;
  logic                 cond;
  logic                 hazard;
  logic [`NUM_REGS-1:0] busy;
  decodedT              decoded;

  assign instr     = headData_i.instr;
  assign funct3    = instr[14:12];
  assign rd        = instr[11:7];
  assign rdAddrA_o = instr[19:15];
  assign rdAddrB_o = instr[24:20];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immU = {instr[31:12], 12'b0};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = ADD;
    imm        = '0;
    case (instr[6:0])
      OP: begin
        ctrl.regWrite = 1'b1;
        ctrl.useRs2   = 1'b1;
        case (funct3)
          3'b000:  ctrl.aluOp = instr[30] ? SUB : ADD;
          3'b001:  ctrl.aluOp = SLL;
          3'b010:  ctrl.aluOp = SLT;
          3'b100:  ctrl.aluOp = XOR;
          3'b101:  ctrl.aluOp = SRL;
          3'b110:  ctrl.aluOp = OR;
          3'b111:  ctrl.aluOp = AND;
          default: ctrl.illegal = 1'b1;
        endcase
        if (instr[30] && (funct3 != 3'b000)) ctrl.illegal = 1'b1;  // SRA and friends
      end
      OP_IMM: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        imm           = immI;
        case (funct3)
          3'b000:  ctrl.aluOp = ADD;
          3'b010:  ctrl.aluOp = SLT;
          3'b100:  ctrl.aluOp = XOR;
          3'b110:  ctrl.aluOp = OR;
          3'b111:  ctrl.aluOp = AND;
          default: ctrl.illegal = 1'b1;  // No immediate shifts or SLTIU
        endcase
      end
      LUI: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = PASSB;
        imm           = immU;
      end
      BRANCH: begin
        ctrl.isBranch = 1'b1;
        ctrl.useRs2   = 1'b1;
        if (funct3[2:1] == 2'b01 || funct3[2:1] == 2'b11) ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // Illegal instructions only retire, they touch no state
    if (ctrl.illegal) begin
      ctrl.regWrite = 1'b0;
      ctrl.useRs2   = 1'b0;
      ctrl.isBranch = 1'b0;
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  cond = (rdDataA_i == rdDataB_i);
      3'b001:  cond = (rdDataA_i != rdDataB_i);
      3'b100:  cond = ($signed(rdDataA_i) < $signed(rdDataB_i));
      3'b101:  cond = ($signed(rdDataA_i) >= $signed(rdDataB_i));
      default: cond = 1'b0;
    endcase
  end

  // rd busy is checked too, so an older write cannot release a newer one's mark
  assign hazard = busy[rdAddrA_o]
                || (ctrl.useRs2 && busy[rdAddrB_o])
                || (ctrl.regWrite && busy[rd]);
  assign take_o = headValid_i && !hazard;

  always_comb begin
    decoded.pc           = headData_i.pc;
    decoded.rd           = rd;
    decoded.regWrite     = ctrl.regWrite;
    decoded.aluOp        = ctrl.aluOp;
    decoded.opA          = rdDataA_i;
    decoded.opB          = ctrl.useImm ? imm : rdDataB_i;
    decoded.isBranch     = ctrl.isBranch;
    decoded.branchTaken  = ctrl.isBranch && cond;
    decoded.branchTarget = headData_i.pc + immB;
    decoded.illegal      = ctrl.illegal;
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      busy <= '0;
    end else begin
      if (releaseEn_i) busy[releaseAddr_i] <= 1'b0;
      if (take_o && ctrl.regWrite && (rd != '0)) busy[rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) exOut.valid <= 1'b0;
    else exOut.valid <= take_o;
  end

  always_ff @(posedge clk_i) begin
    if (take_o) exOut.data <= decoded;
  end

  // At most one writer per register in flight
  noDoubleMark: assert property (@(posedge clk_i) disable iff (!rstN_i)
    (take_o && ctrl.regWrite && (rd != '0)) |-> !busy[rd]);

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module executeStage (
  input  logic       clk_i,
  input  logic       rstN_i,
  decodeExIf.sink    exIn,
  exResultIf.source  resOut
);
  import coreTypes_pkg::*;

  wordT opA;
  wordT opB;
  wordT aluRes;
  logic less;

  assign opA  = exIn.data.opA;
  assign opB  = exIn.data.opB;
  assign less = ($signed(opA) < $signed(opB));

  always_comb begin
    case (exIn.data.aluOp)
      ADD:     aluRes = opA + opB;
      SUB:     aluRes = opA - opB;
      AND:     aluRes = opA & opB;
      OR:      aluRes = opA | opB;
      XOR:     aluRes = opA ^ opB;
      SLT:     aluRes = {{(`XLEN-1){1'b0}}, less};
      SLL:     aluRes = opA << opB[4:0];  // Shamt is the low 5 bits
      SRL:     aluRes = opA >> opB[4:0];
      PASSB:   aluRes = opB;
      default: aluRes = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) resOut.valid <= 1'b0;
    else resOut.valid <= exIn.valid;
  end

  always_ff @(posedge clk_i) begin
    if (exIn.valid) begin
      resOut.data.pc           <= exIn.data.pc;
      resOut.data.rd           <= exIn.data.rd;
      resOut.data.regWrite     <= exIn.data.regWrite;
      resOut.data.value        <= aluRes;
      resOut.data.isBranch     <= exIn.data.isBranch;
      resOut.data.branchTaken  <= exIn.data.branchTaken;
      resOut.data.branchTarget <= exIn.data.branchTarget;
      resOut.data.illegal      <= exIn.data.illegal;
    end
  end

endmodule

/* verilog/instrQueue.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instrQueue (
  input  logic                 clk_i,
  input  logic                 rstN_i,
  input  logic                 inValid_i,
  input  coreTypes_pkg::instrT inData_i,
  input  logic                 take_i,
  output logic                 headValid_o,
  output coreTypes_pkg::instrT headData_o,
  output logic                 creditReturn_o
);
  import coreTypes_pkg::*;

  localparam int PtrW = $clog2(`QUEUE_DEPTH);

  instrT           mem [`QUEUE_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            push;
  logic            pop;

  assign headValid_o = (count != '0);
  assign headData_o  = mem[rdPtr];
  assign push        = inValid_i && (count < `QUEUE_DEPTH);
  assign pop         = take_i && headValid_o;

  always_ff @(posedge clk_i) begin
    if (push) mem[wrPtr] <= inData_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      wrPtr          <= '0;
      rdPtr          <= '0;
      count          <= '0;
      creditReturn_o <= 1'b0;
    end else begin
      if (push) wrPtr <= (wrPtr == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop) rdPtr <= (rdPtr == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count          <= count + push - pop;
      creditReturn_o <= pop;  // One credit back per entry handed to decode
    end
  end

  // Sender spent a credit it did not have
  noOverflow: assert property (@(posedge clk_i) disable iff (!rstN_i)
    inValid_i |-> (count < `QUEUE_DEPTH));

  // Decode only takes a valid head
  noUnderflow: assert property (@(posedge clk_i) disable iff (!rstN_i)
    take_i |-> (count != '0));

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module regFile (
  input  logic                         clk_i,
  input  logic [$clog2(`NUM_REGS)-1:0] rdAddrA_i,
  input  logic [$clog2(`NUM_REGS)-1:0] rdAddrB_i,
  output logic [`XLEN-1:0]             rdDataA_o,
  output logic [`XLEN-1:0]             rdDataB_o,
  input  logic                         wrEn_i,
  input  logic [$clog2(`NUM_REGS)-1:0] wrAddr_i,
  input  logic [`XLEN-1:0]             wrData_i,
  output logic [`XLEN-1:0]             a0_o
);

  localparam int A0Idx = 10;

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 is hardwired, its storage is never read
  assign rdDataA_o = (rdAddrA_i == '0) ? '0 : regs[rdAddrA_i];
  assign rdDataB_o = (rdAddrB_i == '0) ? '0 : regs[rdAddrB_i];

  assign a0_o = regs[A0Idx];

  always_ff @(posedge clk_i) begin
    if (wrEn_i && (wrAddr_i != '0)) begin
      regs[wrAddr_i] <= wrData_i;
    end
  end

endmodule

/* verilog/resultStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module resultStage (
  input  logic                   clk_i,
  input  logic                   rstN_i,
  exResultIf.sink                resIn,
  output logic                   wrEn_o,
  output coreTypes_pkg::regAddrT wrAddr_o,
  output coreTypes_pkg::wordT    wrData_o,
  output logic                   retireValid_o,
  output coreTypes_pkg::wordT    retirePc_o,
  output coreTypes_pkg::regAddrT retireRd_o,
  output logic                   retireWrite_o,
  output coreTypes_pkg::wordT    retireValue_o,
  output logic                   retireBranch_o,
  output logic                   retireTaken_o,
  output coreTypes_pkg::wordT    retireTarget_o,
  output logic                   retireIllegal_o
);

  // Write-back lands on the same edge as the retire registers
  assign wrEn_o   = resIn.valid && resIn.data.regWrite && (resIn.data.rd != '0);
  assign wrAddr_o = resIn.data.rd;
  assign wrData_o = resIn.data.value;

  always_ff @(posedge clk_i) begin
    if (!rstN_i) retireValid_o <= 1'b0;
    else retireValid_o <= resIn.valid;
  end

  always_ff @(posedge clk_i) begin
    if (resIn.valid) begin
      retirePc_o      <= resIn.data.pc;
      retireRd_o      <= resIn.data.rd;
      retireWrite_o   <= resIn.data.regWrite;  // x0 writes still reported
      retireValue_o   <= resIn.data.value;
      retireBranch_o  <= resIn.data.isBranch;
      retireTaken_o   <= resIn.data.branchTaken;
      retireTarget_o  <= resIn.data.branchTarget;
      retireIllegal_o <= resIn.data.illegal;
    end
  end

endmodule

/* verilog/riscCore.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module riscCore (
  input  logic                         clk_i,
  input  logic                         rstN_i,
  input  logic                         instrValid_i,
  input  logic [31:0]                  instr_i,
  input  logic [`XLEN-1:0]             pc_i,
  output logic                         creditReturn_o,
  output logic                         retireValid_o,
  output logic [`XLEN-1:0]             retirePc_o,
  output logic [$clog2(`NUM_REGS)-1:0] retireRd_o,
  output logic                         retireWrite_o,
  output logic [`XLEN-1:0]             retireValue_o,
  output logic                         retireBranch_o,
  output logic                         retireTaken_o,
  output logic [`XLEN-1:0]             retireTarget_o,
  output logic                         retireIllegal_o,
  output logic [`XLEN-1:0]             a0_o
);
  import coreTypes_pkg::*;

  instrT   inData;
  instrT   headData;
  logic    headValid;
  logic    take;
  regAddrT rdAddrA;
  regAddrT rdAddrB;
  wordT    rdDataA;
  wordT    rdDataB;
  logic    wrEn;
  regAddrT wrAddr;
  wordT    wrData;

  decodeExIf deIf ();
  exResultIf erIf ();

  assign inData = '{instr: instr_i, pc: pc_i};

  instrQueue u_instrQueue (
    .clk_i          (clk_i),
    .rstN_i         (rstN_i),
    .inValid_i      (instrValid_i),
    .inData_i       (inData),
    .take_i         (take),
    .headValid_o    (headValid),
    .headData_o     (headData),
    .creditReturn_o (creditReturn_o)
  );

  regFile u_regFile (
    .clk_i     (clk_i),
    .rdAddrA_i (rdAddrA),
    .rdAddrB_i (rdAddrB),
    .rdDataA_o (rdDataA),
    .rdDataB_o (rdDataB),
    .wrEn_i    (wrEn),
    .wrAddr_i  (wrAddr),
    .wrData_i  (wrData),
    .a0_o      (a0_o)
  );

  decodeStage u_decodeStage (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .headValid_i   (headValid),
    .headData_i    (headData),
    .take_o        (take),
    .rdAddrA_o     (rdAddrA),
    .rdAddrB_o     (rdAddrB),
    .rdDataA_i     (rdDataA),
    .rdDataB_i     (rdDataB),
    .releaseEn_i   (wrEn),     // Scoreboard release rides on write-back
    .releaseAddr_i (wrAddr),
    .exOut         (deIf.source)
  );

  executeStage u_executeStage (
    .clk_i  (clk_i),
    .rstN_i (rstN_i),
    .exIn   (deIf.sink),
    .resOut (erIf.source)
  );

  resultStage u_resultStage (
    .clk_i           (clk_i),
    .rstN_i          (rstN_i),
    .resIn           (erIf.sink),
    .wrEn_o          (wrEn),
    .wrAddr_o        (wrAddr),
    .wrData_o        (wrData),
    .retireValid_o   (retireValid_o),
    .retirePc_o      (retirePc_o),
    .retireRd_o      (retireRd_o),
    .retireWrite_o   (retireWrite_o),
    .retireValue_o   (retireValue_o),
    .retireBranch_o  (retireBranch_o),
    .retireTaken_o   (retireTaken_o),
    .retireTarget_o  (retireTarget_o),
    .retireIllegal_o (retireIllegal_o)
  );

endmodule

/* verilog/stageIf.sv */
`timescale 1ns/1ps

// Decode to execute, execute always accepts so there is no ready
interface decodeExIf;
  import coreTypes_pkg::*;

  logic    valid;
  decodedT data;

  modport source (
    output valid,
    output data
  );

  modport sink (
    input valid,
    input data
  );
endinterface

// Execute to result
interface exResultIf;
  import coreTypes_pkg::*;

  logic   valid;
  resultT data;

  modport source (
    output valid,
    output data
  );

  modport sink (
    input valid,
    input data
  );
endinterface
